//--- logic/ex_pkg.sv
package ex_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    parameter int xlen  = 32;
    parameter int tag_w = 5;

    typedef logic [xlen-1:0]  word_t;
    typedef logic [tag_w-1:0] tag_t;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MULT,
        FU_BRANCH
    } fu_kind_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MUL,
        OP_MULHU
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_e;

    typedef enum logic [2:0] {
        COND_EQ,
        COND_NE,
        COND_LT,
        COND_GE,
        COND_LTU,
        COND_GEU
    } br_cond_e;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////

    typedef struct packed {
        logic     valid;
        fu_kind_e fu;
        alu_op_e  op;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        br_cond_e cond;
        logic     cond_branch;
        logic     uncond_branch;
        word_t    pc;
        word_t    rs1;
        word_t    rs2;
        // already sign-extended
        word_t    imm;
        tag_t     tag;
    } ex_issue_t;

    typedef struct packed {
        word_t result;
        logic  take_branch;
        tag_t  tag;
    } fu_result_t;

    typedef struct packed {
        logic     valid;
        fu_kind_e fu;
        word_t    result;
        logic     take_branch;
        tag_t     tag;
    } ex_result_t;

    typedef struct packed {
        logic alu;
        logic mult;
        logic branch;
    } fu_free_t;

endpackage

//--- logic/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  ex_pkg::ex_issue_t issue,
    output ex_pkg::word_t     opa,
    output ex_pkg::word_t     opb
);
    import ex_pkg::*;

    // operand a
    always_comb begin
        case (issue.opa_sel)
            OPA_RS1:  opa = issue.rs1;
            OPA_PC:   opa = issue.pc;
            OPA_ZERO: opa = '0;
            default:  opa = '0;
        endcase
    end

    // operand b, immediate comes in sign-extended
    always_comb begin
        case (issue.opb_sel)
            OPB_RS2: opb = issue.rs2;
            OPB_IMM: opb = issue.imm;
            default: opb = '0;
        endcase
    end

endmodule

//--- logic/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  logic               en,
    input  ex_pkg::alu_op_e    op,
    input  ex_pkg::word_t      opa,
    input  ex_pkg::word_t      opb,
    input  ex_pkg::tag_t       tag,
    output ex_pkg::fu_result_t out_result,
    output logic               done
);
    import ex_pkg::*;

    logic [4:0] shamt;
    word_t      alu_out;

    assign shamt = opb[4:0];

    always_comb begin
        case (op)
            OP_ADD:  alu_out = opa + opb;
            OP_SUB:  alu_out = opa - opb;
            OP_AND:  alu_out = opa & opb;
            OP_OR:   alu_out = opa | opb;
            OP_XOR:  alu_out = opa ^ opb;
            OP_SLT:  alu_out = word_t'($signed(opa) < $signed(opb));
            OP_SLTU: alu_out = word_t'(opa < opb);
            OP_SLL:  alu_out = opa << shamt;
            OP_SRL:  alu_out = opa >> shamt;
            OP_SRA:  alu_out = word_t'($signed(opa) >>> shamt);
            // multiplies belong to the multiplier
            default: alu_out = '0;
        endcase
    end

    assign out_result.result      = alu_out;
    assign out_result.take_branch = 1'b0;
    assign out_result.tag         = tag;

    // single cycle, finishes as soon as it is enabled
    assign done = en;

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  logic               en,
    input  ex_pkg::br_cond_e   cond,
    input  logic               cond_branch,
    input  logic               uncond_branch,
    input  ex_pkg::word_t      rs1,
    input  ex_pkg::word_t      rs2,
    input  ex_pkg::word_t      opa,
    input  ex_pkg::word_t      opb,
    input  ex_pkg::tag_t       tag,
    output ex_pkg::fu_result_t out_result,
    output logic               done
);
    import ex_pkg::*;

    logic cond_true;

    // compare is on the register values, not the operand muxes
    always_comb begin
        case (cond)
            COND_EQ:  cond_true = (rs1 == rs2);
            COND_NE:  cond_true = (rs1 != rs2);
            COND_LT:  cond_true = ($signed(rs1) < $signed(rs2));
            COND_GE:  cond_true = ($signed(rs1) >= $signed(rs2));
            COND_LTU: cond_true = (rs1 < rs2);
            COND_GEU: cond_true = (rs1 >= rs2);
            default:  cond_true = 1'b0;
        endcase
    end

    // target address
    assign out_result.result      = opa + opb;
    assign out_result.take_branch = uncond_branch | (cond_branch & cond_true);
    assign out_result.tag         = tag;

    assign done = en;

endmodule

//--- logic/mul_control.sv
`timescale 1ns/10ps

module mul_control (
    input  logic clock,
    input  logic arst_n,
    input  logic rollback,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic done
);
    import ex_pkg::*;

    mul_state_e state;
    mul_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            MUL_IDLE: begin
                if (start) begin
                    state_next = MUL_BUSY;
                end
            end
            MUL_BUSY: begin
                // step at count zero is the final one
                if (last) begin
                    state_next = MUL_DONE;
                end
            end
            MUL_DONE: state_next = MUL_IDLE;
            default:  state_next = MUL_IDLE;
        endcase
        // abort any multiply in flight
        if (rollback) begin
            state_next = MUL_IDLE;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= MUL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign load = (state == MUL_IDLE) && start && !rollback;
    assign step = (state == MUL_BUSY);
    assign done = (state == MUL_DONE);

endmodule

//--- logic/mul_step_counter.sv
`timescale 1ns/10ps

module mul_step_counter #(
    parameter int mul_bits_per_step = 4
) (
    input  logic clock,
    input  logic arst_n,
    input  logic load,
    input  logic step,
    output logic last
);
    import ex_pkg::*;

    localparam int steps = xlen / mul_bits_per_step;
    localparam int cnt_w = (steps > 1) ? $clog2(steps) : 1;

    logic [cnt_w-1:0] count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= cnt_w'(steps - 1);
        end else if (step && !last) begin
            count <= count - 1'b1;
        end
    end

    assign last = (count == '0);

endmodule

//--- logic/mul_datapath.sv
`timescale 1ns/10ps

module mul_datapath #(
    parameter int mul_bits_per_step = 4
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               load,
    input  logic               step,
    input  ex_pkg::alu_op_e    op,
    input  ex_pkg::word_t      opa,
    input  ex_pkg::word_t      opb,
    input  ex_pkg::tag_t       tag,
    output ex_pkg::fu_result_t out_result
);
    import ex_pkg::*;

    // multiplicand is kept double width and shifts up each step
    logic [2*xlen-1:0] mcand_q;
    word_t             mplier_q;
    alu_op_e           op_q;
    tag_t              tag_q;
    logic [2*xlen-1:0] acc;
    logic [2*xlen-1:0] partial;

    assign partial = mcand_q * mplier_q[mul_bits_per_step-1:0];

    //////////////////////////////////////////////////
    // operand registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            mcand_q  <= {{xlen{1'b0}}, opa};
            mplier_q <= opb;
            op_q     <= op;
            tag_q    <= tag;
        end else if (step) begin
            mcand_q  <= mcand_q << mul_bits_per_step;
            mplier_q <= mplier_q >> mul_bits_per_step;
        end
    end

    // product accumulator
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (load) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc + partial;
        end
    end

    // MULHU takes the upper word, unsigned
    assign out_result.result      = (op_q == OP_MULHU) ? acc[2*xlen-1:xlen] : acc[xlen-1:0];
    assign out_result.take_branch = 1'b0;
    assign out_result.tag         = tag_q;

endmodule

//--- logic/completion_arbiter.sv
`timescale 1ns/10ps

module completion_arbiter (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               rollback,
    input  logic               alu_done,
    input  ex_pkg::fu_result_t alu_in,
    input  logic               mult_done,
    input  ex_pkg::fu_result_t mult_in,
    input  logic               branch_done,
    input  ex_pkg::fu_result_t branch_in,
    output ex_pkg::ex_result_t result,
    output ex_pkg::fu_free_t   free
);
    import ex_pkg::*;

    fu_result_t alu_q;
    fu_result_t mult_q;
    fu_result_t branch_q;
    logic       alu_wait;
    logic       mult_wait;
    logic       branch_wait;
    fu_free_t   grant;
    fu_result_t sel;
    fu_result_t out_q;
    logic       out_valid;
    fu_free_t   free_q;
    fu_kind_e   out_fu;

    //////////////////////////////////////////////////
    // holding registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alu_done) begin
            alu_q <= alu_in;
        end
        if (mult_done) begin
            mult_q <= mult_in;
        end
        if (branch_done) begin
            branch_q <= branch_in;
        end
    end

    // fixed priority, alu first and branch last
    assign grant.alu    = alu_wait;
    assign grant.mult   = mult_wait & ~alu_wait;
    assign grant.branch = branch_wait & ~alu_wait & ~mult_wait;

    always_comb begin
        sel = alu_q;
        if (grant.mult) begin
            sel = mult_q;
        end else if (grant.branch) begin
            sel = branch_q;
        end
    end

    //////////////////////////////////////////////////
    // waiting flags and output strobes
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_wait    <= 1'b0;
            mult_wait   <= 1'b0;
            branch_wait <= 1'b0;
            out_valid   <= 1'b0;
            free_q      <= '0;
        end else if (rollback) begin
            // flush wins over a same-cycle capture
            alu_wait    <= 1'b0;
            mult_wait   <= 1'b0;
            branch_wait <= 1'b0;
            out_valid   <= 1'b0;
            free_q      <= '0;
        end else begin
            alu_wait    <= alu_done | (alu_wait & ~grant.alu);
            mult_wait   <= mult_done | (mult_wait & ~grant.mult);
            branch_wait <= branch_done | (branch_wait & ~grant.branch);
            out_valid   <= alu_wait | mult_wait | branch_wait;
            free_q      <= grant;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_wait || mult_wait || branch_wait) begin
            out_q <= sel;
        end
    end

    // unit kind follows from the one-hot free strobe
    always_comb begin
        out_fu = FU_ALU;
        if (free_q.mult) begin
            out_fu = FU_MULT;
        end else if (free_q.branch) begin
            out_fu = FU_BRANCH;
        end
    end

    assign result.valid       = out_valid;
    assign result.fu          = out_fu;
    assign result.result      = out_q.result;
    assign result.take_branch = out_q.take_branch;
    assign result.tag         = out_q.tag;
    assign free               = free_q;

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/10ps

module ex_stage #(
    parameter int mul_bits_per_step = 4
) (
    input  logic              clock,
    input  logic              arst_n,
    input  ex_pkg::ex_issue_t issue,
    input  logic              rollback,
    output ex_pkg::ex_result_t result,
    output ex_pkg::fu_free_t  free
);
    import ex_pkg::*;

    word_t      opa;
    word_t      opb;
    logic       alu_en;
    logic       mult_en;
    logic       branch_en;
    fu_result_t alu_res;
    fu_result_t branch_res;
    fu_result_t mult_res;
    logic       alu_done;
    logic       branch_done;
    logic       mul_done;
    logic       mul_load;
    logic       mul_step;
    logic       mul_last;

    // unit enables, decoded once here
    assign alu_en    = issue.valid && (issue.fu == FU_ALU);
    assign mult_en   = issue.valid && (issue.fu == FU_MULT);
    assign branch_en = issue.valid && (issue.fu == FU_BRANCH);

    operand_select operand_select_i (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    int_alu int_alu_i (
        .en         (alu_en),
        .op         (issue.op),
        .opa        (opa),
        .opb        (opb),
        .tag        (issue.tag),
        .out_result (alu_res),
        .done       (alu_done)
    );

    branch_unit branch_unit_i (
        .en            (branch_en),
        .cond          (issue.cond),
        .cond_branch   (issue.cond_branch),
        .uncond_branch (issue.uncond_branch),
        .rs1           (issue.rs1),
        .rs2           (issue.rs2),
        .opa           (opa),
        .opb           (opb),
        .tag           (issue.tag),
        .out_result    (branch_res),
        .done          (branch_done)
    );

    //////////////////////////////////////////////////
    // iterative multiplier
    //////////////////////////////////////////////////

    mul_control mul_control_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .rollback (rollback),
        .start    (mult_en),
        .last     (mul_last),
        .load     (mul_load),
        .step     (mul_step),
        .done     (mul_done)
    );

    mul_step_counter #(
        .mul_bits_per_step (mul_bits_per_step)
    ) mul_step_counter_i (
        .clock  (clock),
        .arst_n (arst_n),
        .load   (mul_load),
        .step   (mul_step),
        .last   (mul_last)
    );

    mul_datapath #(
        .mul_bits_per_step (mul_bits_per_step)
    ) mul_datapath_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .load       (mul_load),
        .step       (mul_step),
        .op         (issue.op),
        .opa        (opa),
        .opb        (opb),
        .tag        (issue.tag),
        .out_result (mult_res)
    );

    completion_arbiter completion_arbiter_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .rollback    (rollback),
        .alu_done    (alu_done),
        .alu_in      (alu_res),
        .mult_done   (mul_done),
        .mult_in     (mult_res),
        .branch_done (branch_done),
        .branch_in   (branch_res),
        .result      (result),
        .free        (free)
    );

endmodule

//--- tests/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

//////////////////////////////////////////////////
// operand muxes
//////////////////////////////////////////////////

function automatic word_t select_opa(input ex_issue_t pkt);
    if (pkt.opa_sel == OPA_RS1) begin
        return pkt.rs1;
    end else if (pkt.opa_sel == OPA_PC) begin
        return pkt.pc;
    end
    return '0;
endfunction

function automatic word_t select_opb(input ex_issue_t pkt);
    if (pkt.opb_sel == OPB_IMM) begin
        return pkt.imm;
    end
    return pkt.rs2;
endfunction

// signed compare done on the sign bits first
function automatic logic signed_less(input word_t a, input word_t b);
    if (a[31] != b[31]) begin
        return a[31];
    end
    return a < b;
endfunction

//////////////////////////////////////////////////
// unit results
//////////////////////////////////////////////////

function automatic word_t alu_value(input alu_op_e op, input word_t a, input word_t b);
    logic [63:0] wide;
    int          sh;
    sh   = int'(b[4:0]);
    wide = {{32{a[31]}}, a} >> sh;
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a + ~b + 32'd1;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLT:  return {31'b0, signed_less(a, b)};
        OP_SLTU: return {31'b0, a < b};
        OP_SLL:  return a << sh;
        OP_SRL:  return a >> sh;
        OP_SRA:  return wide[31:0];
        default: return '0;
    endcase
endfunction

function automatic logic branch_taken(input br_cond_e cond, input logic cond_branch,
                                      input logic uncond_branch, input word_t a,
                                      input word_t b);
    logic holds;
    case (cond)
        COND_EQ:  holds = (a == b);
        COND_NE:  holds = (a != b);
        COND_LT:  holds = signed_less(a, b);
        COND_GE:  holds = !signed_less(a, b);
        COND_LTU: holds = (a < b);
        COND_GEU: holds = !(a < b);
        default:  holds = 1'b0;
    endcase
    return uncond_branch || (cond_branch && holds);
endfunction

// full 64-bit unsigned product, low or high word
function automatic word_t product_word(input alu_op_e op, input word_t a, input word_t b);
    logic [63:0] p;
    p = {32'b0, a} * {32'b0, b};
    if (op == OP_MULHU) begin
        return p[63:32];
    end
    return p[31:0];
endfunction

`endif

//--- tests/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb;
    import ex_pkg::*;

    `include "ex_model.svh"

    logic       clock;
    logic       arst_n;
    logic       rollback;
    ex_issue_t  issue;
    ex_result_t result;
    fu_free_t   free;

    integer     seed;
    int         checked;
    tag_t       tag_count;
    ex_result_t expect_q [3];
    logic       pending [3];

    ex_stage #(
        .mul_bits_per_step (4)
    ) dut_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .issue    (issue),
        .rollback (rollback),
        .result   (result),
        .free     (free)
    );

    always #20 clock = ~clock;

    //////////////////////////////////////////////////
    // random stimulus helpers
    //////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // zero, all ones and the sign boundary show up often
    function automatic word_t corner_word();
        case (rand_below(5))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return rand_word();
        endcase
    endfunction

    function automatic word_t imm_word();
        word_t r;
        r = rand_word();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic ex_issue_t alu_packet();
        ex_issue_t pkt;
        pkt         = '0;
        pkt.fu      = FU_ALU;
        pkt.op      = alu_op_e'(rand_below(10));
        pkt.opa_sel = opa_sel_e'(rand_below(3));
        pkt.opb_sel = opb_sel_e'(rand_below(2));
        pkt.pc      = rand_word();
        pkt.rs1     = corner_word();
        pkt.rs2     = corner_word();
        pkt.imm     = imm_word();
        return pkt;
    endfunction

    function automatic ex_issue_t mult_packet();
        ex_issue_t pkt;
        pkt         = '0;
        pkt.fu      = FU_MULT;
        pkt.op      = (rand_below(2) == 1) ? OP_MULHU : OP_MUL;
        pkt.opa_sel = OPA_RS1;
        pkt.opb_sel = OPB_RS2;
        pkt.rs1     = corner_word();
        pkt.rs2     = corner_word();
        return pkt;
    endfunction

    function automatic ex_issue_t branch_packet();
        ex_issue_t pkt;
        pkt               = '0;
        pkt.fu            = FU_BRANCH;
        pkt.cond          = br_cond_e'(rand_below(6));
        pkt.cond_branch   = (rand_below(2) == 1);
        pkt.uncond_branch = (rand_below(4) == 0);
        pkt.opa_sel       = (rand_below(2) == 1) ? OPA_PC : OPA_RS1;
        pkt.opb_sel       = OPB_IMM;
        pkt.pc            = rand_word();
        pkt.rs1           = corner_word();
        pkt.rs2           = corner_word();
        pkt.imm           = imm_word();
        return pkt;
    endfunction

    function automatic string unit_name(input int idx);
        case (idx)
            0:       return "ALU";
            1:       return "multiplier";
            default: return "branch unit";
        endcase
    endfunction

    function automatic fu_free_t free_for_unit(input int idx);
        fu_free_t f;
        f        = '0;
        f.alu    = (idx == 0);
        f.mult   = (idx == 1);
        f.branch = (idx == 2);
        return f;
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(input ex_result_t want, input ex_result_t got);
        if (want.valid == 1'b0) begin
            if (got.valid !== 1'b0) begin
                $display("ERR %0d ns: result.valid is %b with nothing due", $time, got.valid);
                stop_run();
            end
        end else if (got !== want) begin
            $write("ERR %0d ns: result fu %0d tag %0d value %h taken %b,",
                   $time, got.fu, got.tag, got.result, got.take_branch);
            $display(" expected fu %0d tag %0d value %h taken %b",
                     want.fu, want.tag, want.result, want.take_branch);
            stop_run();
        end
    endtask

    task automatic check_free(input fu_free_t want, input fu_free_t got);
        if (got !== want) begin
            $display("ERR %0d ns: free strobes %b, expected %b", $time, got, want);
            stop_run();
        end
    endtask

    // outputs come from registers, so the falling edge sees them settled
    task automatic check_outputs();
        int         idx;
        ex_result_t idle;
        idle = '0;
        if (result.valid === 1'b1) begin
            idx = int'(result.fu);
            if (idx > 2) begin
                $display("ERR %0d ns: result.fu holds unknown unit code %0d", $time, idx);
                stop_run();
            end else if (!pending[idx]) begin
                $display("ERR %0d ns: %s result with nothing outstanding", $time,
                         unit_name(idx));
                stop_run();
            end else begin
                check_result(expect_q[idx], result);
                check_free(free_for_unit(idx), free);
                pending[idx] = 1'b0;
                checked      = checked + 1;
            end
        end else begin
            check_result(idle, result);
            check_free(free_for_unit(3), free);
        end
    endtask

    task automatic tick();
        @(negedge clock);
        check_outputs();
        issue = '0;
    endtask

    //////////////////////////////////////////////////
    // issue and wait
    //////////////////////////////////////////////////

    task automatic wait_unit(input int idx);
        int n;
        n = 0;
        while (pending[idx] && n < 200) begin
            tick();
            n = n + 1;
        end
        if (pending[idx]) begin
            $display("timeout: the %s result never came back within 200 cycles",
                     unit_name(idx));
            stop_run();
        end
    endtask

    task automatic wait_all();
        wait_unit(0);
        wait_unit(1);
        wait_unit(2);
    endtask

    // drives one packet and records what the unit should return
    task automatic issue_op(input ex_issue_t pkt);
        int         idx;
        word_t      a;
        word_t      b;
        ex_result_t want;
        idx = int'(pkt.fu);
        if (pending[idx]) begin
            wait_unit(idx);
        end
        pkt.valid        = 1'b1;
        pkt.tag          = tag_count;
        tag_count        = tag_count + 1'b1;
        a                = select_opa(pkt);
        b                = select_opb(pkt);
        want.valid       = 1'b1;
        want.fu          = pkt.fu;
        want.tag         = pkt.tag;
        want.take_branch = 1'b0;
        case (pkt.fu)
            FU_ALU:  want.result = alu_value(pkt.op, a, b);
            FU_MULT: want.result = product_word(pkt.op, a, b);
            default: begin
                want.result      = a + b;
                want.take_branch = branch_taken(pkt.cond, pkt.cond_branch,
                                                pkt.uncond_branch, pkt.rs1, pkt.rs2);
            end
        endcase
        expect_q[idx] = want;
        pending[idx]  = 1'b1;
        issue         = pkt;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        ex_issue_t pkt;
        word_t     x;
        word_t     y;
        int        c;
        int        kind;
        int        pair;
        int        u;
        int        round;
        seed       = 29206;
        checked    = 0;
        tag_count  = '0;
        clock      = 1'b0;
        arst_n     = 1'b0;
        rollback   = 1'b0;
        issue      = '0;
        pending[0] = 1'b0;
        pending[1] = 1'b0;
        pending[2] = 1'b0;

        // reset state, checked every cycle by the monitor
        repeat (16) tick();
        arst_n = 1'b1;
        repeat (4) tick();

        // random alu ops
        for (round = 0; round < 80; round++) begin
            issue_op(alu_packet());
            tick();
        end
        wait_all();

        // every condition with each flag combination
        for (c = 0; c < 6; c++) begin
            for (kind = 0; kind < 3; kind++) begin
                for (pair = 0; pair < 3; pair++) begin
                    pkt               = branch_packet();
                    pkt.cond          = br_cond_e'(c);
                    pkt.cond_branch   = (kind == 0);
                    pkt.uncond_branch = (kind == 1);
                    x                 = rand_word();
                    case (pair)
                        0: y = x;
                        1: begin
                            x = x | 32'h8000_0000;
                            y = rand_word() & 32'h7fff_ffff;
                        end
                        default: y = rand_word();
                    endcase
                    pkt.rs1 = (rand_below(2) == 1) ? y : x;
                    pkt.rs2 = (pkt.rs1 == x) ? y : x;
                    issue_op(pkt);
                    tick();
                end
            end
        end
        wait_all();

        // multiplies with corner operands
        for (round = 0; round < 40; round++) begin
            issue_op(mult_packet());
            tick();
        end
        wait_all();

        // overlapping traffic on all three units
        for (round = 0; round < 300; round++) begin
            u = rand_below(4);
            if (u < 3 && !pending[u]) begin
                case (u)
                    0:       issue_op(alu_packet());
                    1:       issue_op(mult_packet());
                    default: issue_op(branch_packet());
                endcase
            end
            tick();
        end
        wait_all();

        // flush with work in flight, nothing stale may come out later
        for (round = 0; round < 8; round++) begin
            issue_op(mult_packet());
            tick();
            issue_op(alu_packet());
            tick();
            issue_op(branch_packet());
            tick();
            repeat (rand_below(8)) tick();
            rollback   = 1'b1;
            pending[0] = 1'b0;
            pending[1] = 1'b0;
            pending[2] = 1'b0;
            tick();
            rollback = 1'b0;
            repeat (24) tick();
        end

        // units still work after the flush
        issue_op(mult_packet());
        tick();
        issue_op(branch_packet());
        tick();
        issue_op(alu_packet());
        tick();
        wait_all();
        repeat (4) tick();

        $display("%0d results checked", checked);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- ex_stage.f
+incdir+tests
logic/ex_pkg.sv
logic/operand_select.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/mul_control.sv
logic/mul_step_counter.sv
logic/mul_datapath.sv
logic/completion_arbiter.sv
logic/ex_stage.sv
tests/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - logic/ex_pkg.sv
      - logic/operand_select.sv
      - logic/int_alu.sv
      - logic/branch_unit.sv
      - logic/mul_control.sv
      - logic/mul_step_counter.sv
      - logic/mul_datapath.sv
      - logic/completion_arbiter.sv
      - logic/ex_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ex_stage_tb.sv
